/* project.f */
rtl/rv_m_isa_pkg.sv
rtl/div_cfg_pkg.sv
rtl/div_dispatch.sv
rtl/div_lane.sv
rtl/div_result_collector.sv
rtl/div_unit_top.sv
verification/tb_div_unit.sv

/* Makefile */
# Verilator flow for the divide unit testbench
# Override on the command line, e.g. make VFLAGS="--binary --timing --assert"

TOP       ?= tb_div_unit
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# Pass only when the simulation prints the pass line
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASS"

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

/* verification/tb_div_unit.sv */
`timescale 1ns/1ps
/*
  Self-checking testbench for div_unit_top
  Expected words come from a model of the RV32M rules plus quotient truncation
  Issues always wait for div_unit_busy low, results are matched in issue order
  div_unit_busy is checked against the count of operations still in lanes
  Run length is bounded by a watchdog sized from the number of issues
*/
module tb_div_unit;
  import rv_m_isa_pkg::*;
  import div_cfg_pkg::*;

  localparam int N_EXACT   = 40;
  localparam int N_REM     = 40;
  localparam int N_SPEC    = 6;
  localparam int N_APPROX  = 60;                   // 6 operand pairs x 2 ops x 5 levels
  localparam int N_MIXED   = 40;
  localparam int N_ILLEGAL = 30;
  localparam int N_TOTAL   = N_EXACT + N_REM + N_SPEC + N_APPROX + N_MIXED + N_ILLEGAL;
  localparam int CLK_NS    = 8;
  localparam longint TIMEOUT_NS = longint'(N_TOTAL) * 40 * CLK_NS + 2000;

  localparam logic [ACC_W-1:0] APPROX_LEVELS [5] = '{8'd0, 8'd1, 8'd5, 8'd31, 8'd200};
  localparam logic [ACC_W-1:0] MIX_LEVELS    [4] = '{8'd0, 8'd31, 8'd200, 8'd9};

  logic                CLK;
  logic                rst_n;
  logic                issue;
  logic [OPCODE_W-1:0] opcode;
  logic [FUNCT7_W-1:0] funct7;
  logic [FUNCT3_W-1:0] funct3;
  logic [ACC_W-1:0]    accuracy_level;
  logic [XLEN-1:0]     bus_rs1;
  logic [XLEN-1:0]     bus_rs2;
  logic                div_unit_busy;
  logic                div_valid;
  logic [XLEN-1:0]     div_output;

  integer          seed = 32'h675b1c0f;
  logic [XLEN-1:0] exp_q [$];                      // Expected words, oldest first
  int              err_count   = 0;
  int              valid_count = 0;
  int              legal_count = 0;
  int              pass_tests  = 0;
  int              fail_tests  = 0;
  int              err_mark    = 0;                // Counter values at test start
  int              valid_mark  = 0;
  int              legal_mark  = 0;

  div_unit_top i_dut (
    .CLK            (CLK),
    .rst_n          (rst_n),
    .issue          (issue),
    .opcode         (opcode),
    .funct7         (funct7),
    .funct3         (funct3),
    .accuracy_level (accuracy_level),
    .bus_rs1        (bus_rs1),
    .bus_rs2        (bus_rs2),
    .div_unit_busy  (div_unit_busy),
    .div_valid      (div_valid),
    .div_output     (div_output)
  );

  initial CLK = 1'b0;
  always #(CLK_NS / 2) CLK = ~CLK;

  // RISC-V divide semantics, funct3[0] unsigned, funct3[1] remainder
  function automatic logic [XLEN-1:0] ref_div(input logic [2:0] f3, input logic [XLEN-1:0] a,
                                              input logic [XLEN-1:0] b,
                                              input logic [ACC_W-1:0] acc);
    logic            sgn;
    logic            want_q;
    logic [XLEN-1:0] ma;
    logic [XLEN-1:0] mb;
    logic [XLEN-1:0] q;
    logic [XLEN-1:0] r;
    int              k;
    sgn    = !f3[0];
    want_q = !f3[1];
    if (b == '0)
      return want_q ? {XLEN{1'b1}} : a;          // Divide by zero
    if (sgn && a == 32'h8000_0000 && b == 32'hffff_ffff)
      return want_q ? a : '0;                    // Signed overflow
    ma = (sgn && a[XLEN-1]) ? -a : a;
    mb = (sgn && b[XLEN-1]) ? -b : b;
    q  = ma / mb;
    r  = ma % mb;
    k  = want_q ? ((acc > 8'd31) ? 31 : int'(acc)) : 0;
    q  = (q >> k) << k;                          // Skipped iterations leave zeros
    if (want_q)
      return (sgn && (a[XLEN-1] ^ b[XLEN-1])) ? -q : q;
    return (sgn && a[XLEN-1]) ? -r : r;
  endfunction

  // Random divisor of random size, occasionally negated, never zero
  function automatic logic [XLEN-1:0] pick_divisor();
    logic [XLEN-1:0] v;
    int              shamt;
    v     = XLEN'($random(seed));
    shamt = $unsigned($random(seed)) % 32;
    v     = v >> shamt;
    if ($random(seed) % 4 == 0)
      v = -v;
    if (v == '0)
      v = 32'd3;
    return v;
  endfunction

  // One issue pulse, any encoding, after back-pressure clears
  task automatic send(input logic [OPCODE_W-1:0] opc, input logic [FUNCT7_W-1:0] f7,
                      input logic [FUNCT3_W-1:0] f3, input logic [XLEN-1:0] a,
                      input logic [XLEN-1:0] b, input logic [ACC_W-1:0] acc);
    logic busy_exp;
    forever begin
      busy_exp = (legal_count - valid_count) >= NUM_LANES;  // Every lane holds an older op
      if (div_unit_busy !== busy_exp) begin
        $display("error at %0t ns: div_unit_busy = %b, expected %b", $time, div_unit_busy,
                 busy_exp);
        err_count++;
      end
      if (!div_unit_busy)
        break;
      @(posedge CLK);
      #1;
    end
    issue          = 1'b1;
    opcode         = opc;
    funct7         = f7;
    funct3         = f3;
    bus_rs1        = a;
    bus_rs2        = b;
    accuracy_level = acc;
    if (opc == OPCODE_OP && f7 == FUNCT7_MULDIV && f3[2]) begin   // Divide group only
      exp_q.push_back(ref_div(f3, a, b, acc));
      legal_count++;
    end
    @(posedge CLK);
    #1;
    issue = 1'b0;
  endtask

  task automatic send_op(input logic [FUNCT3_W-1:0] f3, input logic [XLEN-1:0] a,
                         input logic [XLEN-1:0] b, input logic [ACC_W-1:0] acc);
    send(OPCODE_OP, FUNCT7_MULDIV, f3, a, b, acc);
  endtask

  // Drain, then check result count against legal issues
  task automatic close_test(input string name);
    int got;
    int want;
    while (exp_q.size() != 0) begin
      @(posedge CLK);
      #1;
    end
    repeat (6) @(posedge CLK);                   // Room for a stray valid
    #1;
    got  = valid_count - valid_mark;
    want = legal_count - legal_mark;
    if (got != want) begin
      $display("%s: %0d results returned for %0d legal issues", name, got, want);
      err_count++;
    end
    if (err_count == err_mark) begin
      pass_tests++;
      $display("test %s passed, %0d results", name, got);
    end else begin
      fail_tests++;
      $display("test %s failed, %0d errors", name, err_count - err_mark);
    end
    err_mark   = err_count;
    valid_mark = valid_count;
    legal_mark = legal_count;
  endtask

  // Compare at the falling edge, away from the registered outputs
  always @(negedge CLK) begin : compare_results
    logic [XLEN-1:0] expected;
    if (rst_n && div_valid) begin
      valid_count++;
      if (exp_q.size() == 0) begin
        $display("div_valid at %0t ns with no operation outstanding", $time);
        err_count++;
      end else begin
        expected = exp_q.pop_front();
        if (div_output !== expected) begin
          $display("error at %0t ns: div_output = %h, expected %h", $time, div_output, expected);
          err_count++;
        end
      end
    end
  end

  initial begin : stimulus
    int               i;
    int               p;
    int               lvl;
    int               kind;
    logic [XLEN-1:0]  a;
    logic [XLEN-1:0]  b;
    logic [2:0]       f3;
    rst_n          = 1'b0;
    issue          = 1'b0;
    opcode         = '0;
    funct7         = '0;
    funct3         = '0;
    accuracy_level = '0;
    bus_rs1        = '0;
    bus_rs2        = '0;
    repeat (5) @(posedge CLK);
    #1;
    rst_n = 1'b1;
    @(posedge CLK);
    #1;

    for (i = 0; i < N_EXACT; i++) begin          // Top bit set about half the time
      a = XLEN'($random(seed));
      b = pick_divisor();
      send_op((i % 2 == 0) ? FUNCT3_DIV : FUNCT3_DIVU, a, b, 8'd0);
    end
    close_test("exact div/divu");

    for (i = 0; i < N_REM; i++) begin            // Accuracy must not touch remainders
      a = XLEN'($random(seed));
      b = pick_divisor();
      send_op((i % 2 == 0) ? FUNCT3_REM : FUNCT3_REMU, a, b, ACC_W'($random(seed)));
    end
    close_test("rem/remu");

    send_op(FUNCT3_DIV,  32'h1234_5678, 32'h0, 8'd0);
    send_op(FUNCT3_DIVU, 32'h8000_0001, 32'h0, 8'd17);
    send_op(FUNCT3_REM,  32'hdead_beef, 32'h0, 8'd0);
    send_op(FUNCT3_REMU, 32'h0000_0007, 32'h0, 8'd0);
    send_op(FUNCT3_DIV,  32'h8000_0000, 32'hffff_ffff, 8'd0);
    send_op(FUNCT3_REM,  32'h8000_0000, 32'hffff_ffff, 8'd0);
    close_test("special cases");

    for (p = 0; p < N_APPROX / 10; p++) begin
      a = XLEN'($random(seed));
      b = pick_divisor();
      for (lvl = 0; lvl < 5; lvl++) begin        // 200 must behave as 31
        send_op(FUNCT3_DIV,  a, b, APPROX_LEVELS[lvl]);
        send_op(FUNCT3_DIVU, a, b, APPROX_LEVELS[lvl]);
      end
    end
    close_test("approximate div/divu");

    for (i = 0; i < N_MIXED; i++) begin          // Short jobs overtake long ones
      a = XLEN'($random(seed));
      b = pick_divisor();
      if (i % 2 == 1)
        f3 = {2'b10, 1'($random(seed))};
      else
        f3 = {1'b1, 2'($random(seed))};
      send_op(f3, a, b, MIX_LEVELS[i % 4]);
    end
    close_test("back-to-back mixed");

    for (i = 0; i < N_ILLEGAL; i++) begin
      a    = XLEN'($random(seed));
      b    = pick_divisor();
      kind = $unsigned($random(seed)) % 5;
      case (kind)
        0: send(7'b0010011, FUNCT7_MULDIV, FUNCT3_DIV, a, b, 8'd0);    // OP-IMM
        1: send(OPCODE_OP, 7'b0100000, FUNCT3_DIVU, a, b, 8'd0);       // SUB/SRA funct7
        2: send(OPCODE_OP, FUNCT7_MULDIV, {1'b0, 2'($random(seed))}, a, b, 8'd0);  // MUL
        default: send_op({1'b1, 2'($random(seed))}, a, b, 8'd3);
      endcase
    end
    close_test("illegal encodings");

    $display("tests passed %0d, failed %0d, errors %0d", pass_tests, fail_tests, err_count);
    if (fail_tests == 0 && err_count == 0)
      $display("TEST PASS");
    else
      $display("TEST FAIL");
    $finish;
  end

  // Each issue gets a generous 40 cycles
  initial begin : watchdog
    #(TIMEOUT_NS);
    $display("timeout after %0d ns with %0d results outstanding", TIMEOUT_NS, exp_q.size());
    $display("TEST FAIL");
    $finish;
  end

endmodule

/* rtl/div_unit_top.sv */
`timescale 1ns/1ps
/*
  RV32M divide unit, DIV/DIVU/REM/REMU with optional approximation
  Issue only while div_unit_busy is low, results return in issue order
  Variable latency marked by div_valid, three cycles at minimum
*/
module div_unit_top (
  input  logic                              CLK,
  input  logic                              rst_n,
  input  logic                              issue,
  input  logic [rv_m_isa_pkg::OPCODE_W-1:0] opcode,
  input  logic [rv_m_isa_pkg::FUNCT7_W-1:0] funct7,
  input  logic [rv_m_isa_pkg::FUNCT3_W-1:0] funct3,
  input  logic [div_cfg_pkg::ACC_W-1:0]     accuracy_level,
  input  logic [div_cfg_pkg::XLEN-1:0]      bus_rs1,
  input  logic [div_cfg_pkg::XLEN-1:0]      bus_rs2,
  output logic                              div_unit_busy,
  output logic                              div_valid,
  output logic [div_cfg_pkg::XLEN-1:0]      div_output
);
  import rv_m_isa_pkg::*;
  import div_cfg_pkg::*;

  // Dispatcher to lanes, shared buses plus per-lane start
  logic [NUM_LANES-1:0] lane_start;
  div_op_e              lane_op;
  logic [XLEN-1:0]      lane_dividend;
  logic [XLEN-1:0]      lane_divisor;
  logic [ACC_W-1:0]     lane_accuracy;

  // Lanes to collector and back
  logic [NUM_LANES-1:0] lane_idle;
  logic [NUM_LANES-1:0] lane_done;
  logic [NUM_LANES-1:0] lane_release;
  logic [XLEN-1:0]      lane_result [NUM_LANES];

  div_dispatch i_dispatch (
    .CLK            (CLK),
    .rst_n          (rst_n),
    .issue          (issue),
    .opcode         (opcode),
    .funct7         (funct7),
    .funct3         (funct3),
    .accuracy_level (accuracy_level),
    .bus_rs1        (bus_rs1),
    .bus_rs2        (bus_rs2),
    .lane_idle      (lane_idle),
    .lane_start     (lane_start),
    .lane_op        (lane_op),
    .lane_dividend  (lane_dividend),
    .lane_divisor   (lane_divisor),
    .lane_accuracy  (lane_accuracy),
    .div_unit_busy  (div_unit_busy)
  );

  for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
    div_lane i_lane (
      .CLK         (CLK),
      .rst_n       (rst_n),
      .start       (lane_start[i]),
      .op          (lane_op),
      .dividend    (lane_dividend),
      .divisor     (lane_divisor),
      .accuracy    (lane_accuracy),
      .release_req (lane_release[i]),
      .idle        (lane_idle[i]),
      .done        (lane_done[i]),
      .result      (lane_result[i])
    );
  end

  div_result_collector i_collector (
    .CLK          (CLK),
    .rst_n        (rst_n),
    .lane_done    (lane_done),
    .lane_result  (lane_result),
    .lane_release (lane_release),
    .div_valid    (div_valid),
    .div_output   (div_output)
  );

endmodule

/* rtl/div_result_collector.sv */
`timescale 1ns/1ps
/*
  In-order drain of the divider lanes
  Read pointer follows the dispatcher's round-robin order
  div_valid pulses one cycle after the lane at the read pointer shows done
  div_output keeps its value until the next result
*/
module div_result_collector (
  input  logic                              CLK,
  input  logic                              rst_n,
  input  logic [div_cfg_pkg::NUM_LANES-1:0] lane_done,
  input  logic [div_cfg_pkg::XLEN-1:0]      lane_result [div_cfg_pkg::NUM_LANES],
  output logic [div_cfg_pkg::NUM_LANES-1:0] lane_release,
  output logic                              div_valid,
  output logic [div_cfg_pkg::XLEN-1:0]      div_output
);
  import div_cfg_pkg::*;

  logic [LANE_IDX_W-1:0] rd_ptr;   // Oldest outstanding lane
  logic                  head_done;

  // Only the head lane may leave, later finishers wait their turn
  assign head_done = lane_done[rd_ptr];

  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      rd_ptr       <= '0;
      div_valid    <= 1'b0;
      lane_release <= '0;
    end else begin
      div_valid    <= 1'b0;
      lane_release <= '0;
      if (head_done) begin
        div_valid    <= 1'b1;
        lane_release <= {{(NUM_LANES-1){1'b0}}, 1'b1} << rd_ptr;  // Lane idles next edge
        rd_ptr       <= rd_ptr + 1'b1;
      end
    end
  end

  // Result word, captured with the valid pulse
  always_ff @(posedge CLK) begin
    if (head_done)
      div_output <= lane_result[rd_ptr];
  end

  // Head lane keeps done and its word until its release pulse
  a_head_held: assert property (@(posedge CLK) disable iff (!rst_n)
    head_done |=> lane_done[$past(rd_ptr)] && lane_result[$past(rd_ptr)] == div_output)
    else $error("head lane dropped done or changed its result before release");

endmodule

/* rtl/div_lane.sv */
`timescale 1ns/1ps
/*
  One iterative restoring divider lane, one quotient bit per cycle
  Operands are taken on the edge where start is high, only while idle
  DIV/DIVU skip the last min(accuracy, MAX_SKIP) iterations, REM/REMU are exact
  Divide by zero and signed overflow bypass the iterations
  Result and done hold until release_req, then the lane goes idle
*/
module div_lane (
  input  logic                          CLK,
  input  logic                          rst_n,
  input  logic                          start,
  input  rv_m_isa_pkg::div_op_e         op,
  input  logic [div_cfg_pkg::XLEN-1:0]  dividend,
  input  logic [div_cfg_pkg::XLEN-1:0]  divisor,
  input  logic [div_cfg_pkg::ACC_W-1:0] accuracy,
  input  logic                          release_req,
  output logic                          idle,
  output logic                          done,
  output logic [div_cfg_pkg::XLEN-1:0]  result
);
  import rv_m_isa_pkg::*;
  import div_cfg_pkg::*;

  lane_state_e       state_q;
  logic [CNT_W-1:0]  cnt_q;       // Iterations left in RUN
  logic [SKIP_W-1:0] skip_q;      // Low quotient bits left at zero
  logic              is_div_q;    // Quotient selected, else remainder
  logic              neg_quot_q;  // Operand signs differ
  logic              neg_rem_q;   // Dividend negative
  logic              special_q;   // Result already loaded at start
  logic [XLEN-1:0]   dvd_q;       // Dividend magnitude, MSB shifted out first
  logic [XLEN-1:0]   dsr_q;       // Divisor magnitude
  logic [XLEN-1:0]   rem_q;       // Partial remainder, always below divisor
  logic [XLEN-1:0]   quot_q;      // Quotient bits, shifted in at LSB

  logic              in_signed;
  logic              in_div;
  logic              in_special;
  logic [SKIP_W-1:0] in_skip;
  logic [XLEN-1:0]   in_dvd_mag;
  logic [XLEN-1:0]   in_dsr_mag;
  logic [XLEN-1:0]   in_special_res;

  logic [XLEN:0]     rem_shift;   // One extra bit, shifted value below 2x divisor
  logic [XLEN:0]     rem_sub;
  logic              q_bit;
  logic [XLEN-1:0]   quot_mag;
  logic [XLEN-1:0]   quot_fix;
  logic [XLEN-1:0]   rem_fix;

  // Decode of the incoming operation
  always_comb begin
    in_signed = (op == OP_DIV) || (op == OP_REM);
    in_div    = (op == OP_DIV) || (op == OP_DIVU);
    if (!in_div)
      in_skip = '0;                                  // Remainder needs every step
    else if (accuracy > ACC_W'(MAX_SKIP))
      in_skip = SKIP_W'(MAX_SKIP);
    else
      in_skip = accuracy[SKIP_W-1:0];
    in_dvd_mag = (in_signed && dividend[XLEN-1]) ? -dividend : dividend;
    in_dsr_mag = (in_signed && divisor[XLEN-1])  ? -divisor  : divisor;
    if (divisor == '0) begin
      in_special     = 1'b1;
      in_special_res = in_div ? '1 : dividend;       // All ones, or dividend back
    end else if (in_signed && dividend == {1'b1, {(XLEN-1){1'b0}}} && divisor == '1) begin
      in_special     = 1'b1;
      in_special_res = in_div ? dividend : '0;       // Most negative / -1
    end else begin
      in_special     = 1'b0;
      in_special_res = '0;
    end
  end

  // One restoring step
  assign rem_shift = {rem_q, dvd_q[XLEN-1]};
  assign q_bit     = rem_shift >= {1'b0, dsr_q};
  assign rem_sub   = rem_shift - {1'b0, dsr_q};

  // Sign fix, truncated quotient realigned to full weight
  assign quot_mag = quot_q << skip_q;
  assign quot_fix = neg_quot_q ? -quot_mag : quot_mag;
  assign rem_fix  = neg_rem_q ? -rem_q : rem_q;

  assign idle = (state_q == LANE_IDLE);
  assign done = (state_q == LANE_DONE);

  // Control FSM
  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= LANE_IDLE;
      cnt_q   <= '0;
    end else begin
      case (state_q)
        LANE_IDLE: begin
          if (start) begin
            state_q <= in_special ? LANE_FIX : LANE_RUN;
            cnt_q   <= CNT_W'(XLEN) - CNT_W'(in_skip);  // At least one step
          end
        end
        LANE_RUN: begin
          cnt_q <= cnt_q - 1'b1;
          if (cnt_q == CNT_W'(1))
            state_q <= LANE_FIX;
        end
        LANE_FIX: state_q <= LANE_DONE;
        LANE_DONE: begin
          if (release_req)
            state_q <= LANE_IDLE;
        end
        default: state_q <= LANE_IDLE;
      endcase
    end
  end

  // Datapath
  always_ff @(posedge CLK) begin
    if (start && state_q == LANE_IDLE) begin
      skip_q     <= in_skip;
      is_div_q   <= in_div;
      neg_quot_q <= in_signed && (dividend[XLEN-1] ^ divisor[XLEN-1]);
      neg_rem_q  <= in_signed && dividend[XLEN-1];
      special_q  <= in_special;
      dvd_q      <= in_dvd_mag;
      dsr_q      <= in_dsr_mag;
      rem_q      <= '0;
      quot_q     <= '0;
      result     <= in_special_res;                   // Final only for special cases
    end else if (state_q == LANE_RUN) begin
      dvd_q  <= {dvd_q[XLEN-2:0], 1'b0};
      rem_q  <= q_bit ? rem_sub[XLEN-1:0] : rem_shift[XLEN-1:0];
      quot_q <= {quot_q[XLEN-2:0], q_bit};
    end else if (state_q == LANE_FIX && !special_q) begin
      result <= is_div_q ? quot_fix : rem_fix;
    end
  end

  // Dispatcher only targets a lane it saw idle
  a_start_idle: assert property (@(posedge CLK) disable iff (!rst_n)
    start |-> idle)
    else $error("lane start while not idle");

  // Collector only releases a finished lane
  a_release_done: assert property (@(posedge CLK) disable iff (!rst_n)
    release_req |-> done)
    else $error("lane release while not done");

endmodule

/* rtl/div_dispatch.sv */
`timescale 1ns/1ps
/*
  Issue decode and round-robin lane assignment
  Issue is a one-cycle pulse, legal only while div_unit_busy is low
  Illegal encodings and issues while busy are dropped silently
  Start strobe and operand buses are registered, one cycle after issue
*/
module div_dispatch (
  input  logic                                CLK,
  input  logic                                rst_n,
  input  logic                                issue,
  input  logic [rv_m_isa_pkg::OPCODE_W-1:0]   opcode,
  input  logic [rv_m_isa_pkg::FUNCT7_W-1:0]   funct7,
  input  logic [rv_m_isa_pkg::FUNCT3_W-1:0]   funct3,
  input  logic [div_cfg_pkg::ACC_W-1:0]       accuracy_level,
  input  logic [div_cfg_pkg::XLEN-1:0]        bus_rs1,
  input  logic [div_cfg_pkg::XLEN-1:0]        bus_rs2,
  input  logic [div_cfg_pkg::NUM_LANES-1:0]   lane_idle,
  output logic [div_cfg_pkg::NUM_LANES-1:0]   lane_start,
  output rv_m_isa_pkg::div_op_e               lane_op,
  output logic [div_cfg_pkg::XLEN-1:0]        lane_dividend,
  output logic [div_cfg_pkg::XLEN-1:0]        lane_divisor,
  output logic [div_cfg_pkg::ACC_W-1:0]       lane_accuracy,
  output logic                                div_unit_busy
);
  import rv_m_isa_pkg::*;
  import div_cfg_pkg::*;

  logic [LANE_IDX_W-1:0] wr_ptr;   // Next lane to receive an operation
  div_op_e               dec_op;
  logic                  dec_legal;
  logic                  accept;

  // Decode of the R-type fields
  always_comb begin
    dec_op    = OP_DIV;
    dec_legal = 1'b0;
    if (opcode == OPCODE_OP && funct7 == FUNCT7_MULDIV) begin
      dec_legal = 1'b1;
      case (funct3)
        FUNCT3_DIV:  dec_op = OP_DIV;
        FUNCT3_DIVU: dec_op = OP_DIVU;
        FUNCT3_REM:  dec_op = OP_REM;
        FUNCT3_REMU: dec_op = OP_REMU;
        default:     dec_legal = 1'b0;  // MUL group, not ours
      endcase
    end
  end

  // Lane at write pointer still occupied, either running or awaiting collection
  assign div_unit_busy = !lane_idle[wr_ptr];
  assign accept        = issue && dec_legal && !div_unit_busy;

  // Strobe and pointer
  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr     <= '0;
      lane_start <= '0;
    end else begin
      lane_start <= '0;
      if (accept) begin
        lane_start <= {{(NUM_LANES-1){1'b0}}, 1'b1} << wr_ptr;
        wr_ptr     <= wr_ptr + 1'b1;  // Wraps, NUM_LANES is a power of two
      end
    end
  end

  // Shared operand buses, only meaningful alongside a start bit
  always_ff @(posedge CLK) begin
    if (accept) begin
      lane_op       <= dec_op;
      lane_dividend <= bus_rs1;
      lane_divisor  <= bus_rs2;
      lane_accuracy <= accuracy_level;
    end
  end

  // Environment must respect back-pressure
  a_no_issue_busy: assert property (@(posedge CLK) disable iff (!rst_n)
    issue |-> !div_unit_busy)
    else $error("issue raised while div_unit_busy");

  // A started lane leaves idle on the next edge, else the issue is lost
  a_start_taken: assert property (@(posedge CLK) disable iff (!rst_n)
    |lane_start |=> (lane_idle & $past(lane_start)) == '0)
    else $error("started lane still idle");

endmodule

/* rtl/div_cfg_pkg.sv */
/*
  Divide unit datapath configuration
  NUM_LANES must be a power of two from 2 to 8, pointers wrap by overflow
  MAX_SKIP keeps at least one quotient iteration per operation
*/
package div_cfg_pkg;

  localparam int XLEN       = 32;                 // Operand and result width
  localparam int NUM_LANES  = 4;                  // Iterative divider lanes
  localparam int LANE_IDX_W = $clog2(NUM_LANES);  // Round-robin pointer width
  localparam int ACC_W      = 8;                  // Accuracy level width
  localparam int MAX_SKIP   = 31;                 // Cap on skipped iterations

  // Derived counter widths
  localparam int SKIP_W = $clog2(MAX_SKIP + 1);   // Holds 0..MAX_SKIP
  localparam int CNT_W  = $clog2(XLEN + 1);       // Holds 0..XLEN

  // Lane control states
  typedef enum logic [1:0] {
    LANE_IDLE = 2'd0,  // Free for a new start
    LANE_RUN  = 2'd1,  // One quotient bit per cycle
    LANE_FIX  = 2'd2,  // Sign fix or special-case result
    LANE_DONE = 2'd3   // Result held until released
  } lane_state_e;

endpackage

/* rtl/rv_m_isa_pkg.sv */
/*
  RV32M divide group encodings, R-type only
  MUL/MULH variants share FUNCT7_MULDIV but are not decoded by the divide unit
  div_op_e values follow funct3[1:0] of the four divide instructions
*/
package rv_m_isa_pkg;

  // Field widths of the R-type word
  localparam int OPCODE_W = 7;
  localparam int FUNCT7_W = 7;
  localparam int FUNCT3_W = 3;

  // Major opcode OP, register-register ALU group
  localparam logic [OPCODE_W-1:0] OPCODE_OP = 7'b0110011;

  // M extension selector in funct7
  localparam logic [FUNCT7_W-1:0] FUNCT7_MULDIV = 7'b0000001;

  // Divide group funct3 codes
  localparam logic [FUNCT3_W-1:0] FUNCT3_DIV  = 3'b100; // Signed quotient
  localparam logic [FUNCT3_W-1:0] FUNCT3_DIVU = 3'b101; // Unsigned quotient
  localparam logic [FUNCT3_W-1:0] FUNCT3_REM  = 3'b110; // Signed remainder
  localparam logic [FUNCT3_W-1:0] FUNCT3_REMU = 3'b111; // Unsigned remainder

  // Decoded operation carried from dispatcher to lane
  typedef enum logic [1:0] {
    OP_DIV  = 2'b00,
    OP_DIVU = 2'b01,
    OP_REM  = 2'b10,
    OP_REMU = 2'b11
  } div_op_e;

endpackage
